// ==== src/csr_pkg.sv ====
package csr_pkg;

    // bus widths
    localparam int CSR_AW = 14;
    localparam int XLEN   = 32;
    localparam int HWI_W  = 9;
    localparam int IS_W   = 13;
    localparam int SWI_W  = 2;
    localparam int ESUB_W = 9;
    localparam int ECODE_W = 6;

    // crmd / prmd fields
    localparam int PLV_LO  = 0;
    localparam int PLV_W   = 2;
    localparam int IE_BIT  = 2;
    localparam int DA_BIT  = 3;
    localparam int PG_BIT  = 4;
    localparam int PPLV_LO = 0;
    localparam int PIE_BIT = 2;

    // estat fields
    localparam int IS_LO    = 0;
    localparam int HWI_LO   = 2;
    localparam int TI_BIT   = 11;
    localparam int ECODE_LO = 16;
    localparam int ESUB_LO  = 22;

    // eentry base, 64-byte aligned
    localparam int EENTRY_LO = 6;
    localparam int EENTRY_W  = XLEN - EENTRY_LO;

    // timer fields
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int INITVAL_LO        = 2;
    localparam int INITVAL_W         = XLEN - INITVAL_LO;
    localparam int TICLR_CLR_BIT     = 0;

    typedef enum logic [CSR_AW-1:0] {
        CRMD   = 14'h00,
        PRMD   = 14'h01,
        ECTL   = 14'h04,
        ESTAT  = 14'h05,
        ERA    = 14'h06,
        EENTRY = 14'h0c,
        SAVE0  = 14'h30,
        SAVE1  = 14'h31,
        SAVE2  = 14'h32,
        SAVE3  = 14'h33,
        TCFG   = 14'h41,
        TVAL   = 14'h42,
        TICLR  = 14'h44
    } csr_addr_e;

    typedef enum logic [ECODE_W-1:0] {
        INT = 6'h00,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d
    } ecode_e;

endpackage

// ==== src/csr_mode_regs.sv ====
`timescale 1ns/10ps

module csr_mode_regs
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [CSR_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic              excp_flush,
    input  logic              ertn_flush,
    input  ecode_e            ecode,
    input  logic [ESUB_W-1:0] esubcode,
    input  logic [XLEN-1:0]   era_in,
    output logic [XLEN-1:0]   crmd,
    output logic [XLEN-1:0]   prmd,
    output logic [XLEN-1:0]   era,
    output logic [XLEN-1:0]   eentry,
    output ecode_e            ecode_q,
    output logic [ESUB_W-1:0] esubcode_q,
    output logic              crmd_ie,
    output logic [PLV_W-1:0]  plv
);

    logic                crmd_wen;
    logic                prmd_wen;
    logic                era_wen;
    logic                eentry_wen;
    logic [PLV_W-1:0]    plv_q;
    logic                ie_q;
    logic                da_q;
    logic                pg_q;
    logic [PLV_W-1:0]    pplv_q;
    logic                pie_q;
    logic [XLEN-1:0]     era_q;
    logic [EENTRY_W-1:0] eentry_base;

    assign crmd_wen   = wr_en && (wr_addr == CRMD);
    assign prmd_wen   = wr_en && (wr_addr == PRMD);
    assign era_wen    = wr_en && (wr_addr == ERA);
    assign eentry_wen = wr_en && (wr_addr == EENTRY);

    // crmd, exception entry and return take priority over a write
    always_ff @(posedge clk) begin
        if (reset) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
            da_q  <= 1'b1;
            pg_q  <= 1'b0;
        end else if (excp_flush) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
        end else if (ertn_flush) begin
            plv_q <= pplv_q;
            ie_q  <= pie_q;
        end else if (crmd_wen) begin
            plv_q <= wr_data[PLV_LO +: PLV_W];
            ie_q  <= wr_data[IE_BIT];
            da_q  <= wr_data[DA_BIT];
            pg_q  <= wr_data[PG_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pplv_q <= '0;
            pie_q  <= 1'b0;
        end else if (excp_flush) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
        end else if (prmd_wen) begin
            pplv_q <= wr_data[PPLV_LO +: PLV_W];
            pie_q  <= wr_data[PIE_BIT];
        end
    end

    // exception cause
    always_ff @(posedge clk) begin
        if (reset) begin
            ecode_q    <= INT;
            esubcode_q <= '0;
        end else if (excp_flush) begin
            ecode_q    <= ecode;
            esubcode_q <= esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era_q <= era_in;
        end else if (era_wen) begin
            era_q <= wr_data;
        end
        if (eentry_wen) begin
            eentry_base <= wr_data[EENTRY_LO +: EENTRY_W];
        end
    end

    always_comb begin
        crmd = '0;
        crmd[PLV_LO +: PLV_W] = plv_q;
        crmd[IE_BIT] = ie_q;
        crmd[DA_BIT] = da_q;
        crmd[PG_BIT] = pg_q;
        prmd = '0;
        prmd[PPLV_LO +: PLV_W] = pplv_q;
        prmd[PIE_BIT] = pie_q;
    end

    // forwarded so fetch sees the new level in the same cycle
    always_comb begin
        if (excp_flush) begin
            plv = '0;
        end else if (ertn_flush) begin
            plv = pplv_q;
        end else if (crmd_wen) begin
            plv = wr_data[PLV_LO +: PLV_W];
        end else begin
            plv = plv_q;
        end
    end

    assign era     = era_q;
    assign eentry  = {eentry_base, {EENTRY_LO{1'b0}}};
    assign crmd_ie = ie_q;

    // the pipeline retires one flush at a time
    a_flush_onehot: assert property (@(posedge clk) disable iff (reset)
        !(excp_flush && ertn_flush))
        else $error("excp_flush and ertn_flush high together");

endmodule

// ==== src/csr_int_ctrl.sv ====
`timescale 1ns/10ps

module csr_int_ctrl
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [CSR_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic [HWI_W-1:0]  interrupt,
    input  logic              timer_int,
    input  logic              crmd_ie,
    output logic [IS_W-1:0]   estat_is,
    output logic [IS_W-1:0]   ectl_lie,
    output logic              has_int
);

    logic [IS_W-1:0]  lie_q;
    logic [SWI_W-1:0] swi_q;
    logic [HWI_W-1:0] hwi_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            lie_q <= '0;
            swi_q <= '0;
            hwi_q <= '0;
        end else begin
            // hardware lines sampled every cycle
            hwi_q <= interrupt;
            if (wr_en && (wr_addr == ECTL)) begin
                lie_q <= wr_data[IS_LO +: IS_W];
            end
            if (wr_en && (wr_addr == ESTAT)) begin
                swi_q <= wr_data[IS_LO +: SWI_W];
            end
        end
    end

    // bit 12 (inter-processor) stays 0
    always_comb begin
        estat_is = '0;
        estat_is[SWI_W-1:0] = swi_q;
        estat_is[HWI_LO +: HWI_W] = hwi_q;
        estat_is[TI_BIT] = timer_int;
    end

    assign ectl_lie = lie_q;
    assign has_int  = (|(estat_is & lie_q)) && crmd_ie;

endmodule

// ==== src/csr_timer.sv ====
`timescale 1ns/10ps

module csr_timer
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [CSR_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    output logic [XLEN-1:0]   tcfg,
    output logic [XLEN-1:0]   tval,
    output logic              timer_int
);

    logic                 tcfg_wen;
    logic                 ticlr_wen;
    logic                 expire;
    logic                 cfg_en_q;
    logic                 periodic_q;
    logic [INITVAL_W-1:0] initval_q;
    logic                 timer_en;
    logic                 ti_q;
    logic [XLEN-1:0]      tval_q;

    assign tcfg_wen  = wr_en && (wr_addr == TCFG);
    assign ticlr_wen = wr_en && (wr_addr == TICLR);
    assign expire    = timer_en && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_en_q   <= 1'b0;
            periodic_q <= 1'b0;
        end else if (tcfg_wen) begin
            cfg_en_q   <= wr_data[TCFG_EN_BIT];
            periodic_q <= wr_data[TCFG_PERIODIC_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wen) begin
            initval_q <= wr_data[INITVAL_LO +: INITVAL_W];
        end
    end

    // one-shot stops after the first expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            timer_en <= wr_data[TCFG_EN_BIT];
        end else if (expire) begin
            timer_en <= periodic_q;
        end
    end

    // clear wins over a set in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ti_q <= 1'b0;
        end else if (ticlr_wen && wr_data[TICLR_CLR_BIT]) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tval_q <= '0;
        end else if (tcfg_wen) begin
            tval_q <= {wr_data[INITVAL_LO +: INITVAL_W], {INITVAL_LO{1'b0}}};
        end else if (expire) begin
            tval_q <= periodic_q ? {initval_q, {INITVAL_LO{1'b0}}} : '1;
        end else if (timer_en) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    always_comb begin
        tcfg = '0;
        tcfg[TCFG_EN_BIT] = cfg_en_q;
        tcfg[TCFG_PERIODIC_BIT] = periodic_q;
        tcfg[INITVAL_LO +: INITVAL_W] = initval_q;
    end

    assign tval      = tval_q;
    assign timer_int = ti_q;

    // counter frozen while TCFG.EN is clear
    a_tval_hold: assert property (@(posedge clk) disable iff (reset)
        (!cfg_en_q && !tcfg_wen) |=> $stable(tval_q))
        else $error("TVAL changed while timer disabled");

endmodule

// ==== src/csr_read_port.sv ====
`timescale 1ns/10ps

module csr_read_port
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              wr_en,
    input  logic [CSR_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic [CSR_AW-1:0] rd_addr,
    input  logic [XLEN-1:0]   crmd,
    input  logic [XLEN-1:0]   prmd,
    input  logic [XLEN-1:0]   era,
    input  logic [XLEN-1:0]   eentry,
    input  ecode_e            ecode_q,
    input  logic [ESUB_W-1:0] esubcode_q,
    input  logic [IS_W-1:0]   estat_is,
    input  logic [IS_W-1:0]   ectl_lie,
    input  logic [XLEN-1:0]   tcfg,
    input  logic [XLEN-1:0]   tval,
    output logic [XLEN-1:0]   rd_data
);

    logic [XLEN-1:0] save_q [4];
    logic [XLEN-1:0] estat;
    logic [XLEN-1:0] ectl;

    // scratch registers, software data only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_addr)
                SAVE0:   save_q[0] <= wr_data;
                SAVE1:   save_q[1] <= wr_data;
                SAVE2:   save_q[2] <= wr_data;
                SAVE3:   save_q[3] <= wr_data;
                default: ;
            endcase
        end
    end

    always_comb begin
        estat = '0;
        estat[IS_LO +: IS_W] = estat_is;
        estat[ECODE_LO +: ECODE_W] = ecode_q;
        estat[ESUB_LO +: ESUB_W] = esubcode_q;
        ectl = '0;
        ectl[IS_LO +: IS_W] = ectl_lie;
    end

    always_comb begin
        case (rd_addr)
            CRMD:    rd_data = crmd;
            PRMD:    rd_data = prmd;
            ECTL:    rd_data = ectl;
            ESTAT:   rd_data = estat;
            ERA:     rd_data = era;
            EENTRY:  rd_data = eentry;
            SAVE0:   rd_data = save_q[0];
            SAVE1:   rd_data = save_q[1];
            SAVE2:   rd_data = save_q[2];
            SAVE3:   rd_data = save_q[3];
            TCFG:    rd_data = tcfg;
            TVAL:    rd_data = tval;
            // ticlr is write-only
            default: rd_data = '0;
        endcase
    end

endmodule

// ==== src/csr_top.sv ====
`timescale 1ns/10ps

module csr_top
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [CSR_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic [CSR_AW-1:0] rd_addr,
    output logic [XLEN-1:0]   rd_data,
    input  logic              excp_flush,
    input  ecode_e            ecode,
    input  logic [ESUB_W-1:0] esubcode,
    input  logic [XLEN-1:0]   era_in,
    input  logic              ertn_flush,
    input  logic [HWI_W-1:0]  interrupt,
    output logic [XLEN-1:0]   eentry,
    output logic [XLEN-1:0]   era,
    output logic [PLV_W-1:0]  plv,
    output logic              has_int
);

    logic [XLEN-1:0]   crmd;
    logic [XLEN-1:0]   prmd;
    ecode_e            ecode_q;
    logic [ESUB_W-1:0] esubcode_q;
    logic              crmd_ie;
    logic              timer_int;
    logic [XLEN-1:0]   tcfg;
    logic [XLEN-1:0]   tval;
    logic [IS_W-1:0]   estat_is;
    logic [IS_W-1:0]   ectl_lie;

    csr_mode_regs i_csr_mode_regs (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .ecode      (ecode),
        .esubcode   (esubcode),
        .era_in     (era_in),
        .crmd       (crmd),
        .prmd       (prmd),
        .era        (era),
        .eentry     (eentry),
        .ecode_q    (ecode_q),
        .esubcode_q (esubcode_q),
        .crmd_ie    (crmd_ie),
        .plv        (plv)
    );

    csr_int_ctrl i_csr_int_ctrl (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .interrupt (interrupt),
        .timer_int (timer_int),
        .crmd_ie   (crmd_ie),
        .estat_is  (estat_is),
        .ectl_lie  (ectl_lie),
        .has_int   (has_int)
    );

    csr_timer i_csr_timer (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_read_port i_csr_read_port (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .crmd       (crmd),
        .prmd       (prmd),
        .era        (era),
        .eentry     (eentry),
        .ecode_q    (ecode_q),
        .esubcode_q (esubcode_q),
        .estat_is   (estat_is),
        .ectl_lie   (ectl_lie),
        .tcfg       (tcfg),
        .tval       (tval),
        .rd_data    (rd_data)
    );

endmodule

// ==== dv/tb_csr_top.sv ====
`timescale 1ns/10ps

module tb_csr_top
    import csr_pkg::*;
();

    logic              clk;
    logic              reset;
    logic              wr_en;
    logic [CSR_AW-1:0] wr_addr;
    logic [XLEN-1:0]   wr_data;
    logic [CSR_AW-1:0] rd_addr;
    logic [XLEN-1:0]   rd_data;
    logic              excp_flush;
    ecode_e            ecode;
    logic [ESUB_W-1:0] esubcode;
    logic [XLEN-1:0]   era_in;
    logic              ertn_flush;
    logic [HWI_W-1:0]  interrupt;
    logic [XLEN-1:0]   eentry;
    logic [XLEN-1:0]   era;
    logic [PLV_W-1:0]  plv;
    logic              has_int;

    int errors;
    int test_errors;
    int tests_run;
    int checks;

    csr_top i_csr_top (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .excp_flush (excp_flush),
        .ecode      (ecode),
        .esubcode   (esubcode),
        .era_in     (era_in),
        .ertn_flush (ertn_flush),
        .interrupt  (interrupt),
        .eentry     (eentry),
        .era        (era),
        .plv        (plv),
        .has_int    (has_int)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t ns: %s gave %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // combinational read with a short settle
    task automatic read_csr(input logic [CSR_AW-1:0] addr, output logic [XLEN-1:0] data);
        rd_addr = addr;
        #2;
        data = rd_data;
    endtask

    task automatic finish_test(input logic [XLEN-1:0] num);
        $display("test %0d done with %0d errors", num, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    // poll ESTAT.TI once per cycle while TVAL counts down
    task automatic wait_timer_bit(input int limit);
        logic [XLEN-1:0] prev;
        logic [XLEN-1:0] now;
        logic [XLEN-1:0] stat;
        int cycles;
        bit seen;
        prev = '1;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            #86;
            read_csr(ESTAT, stat);
            seen = stat[TI_BIT];
            checks++;
            assert (!(seen && cycles == 0)) else begin
                $display("ERR %0t ns: timer bit already set before the countdown", $time);
                errors++;
                test_errors++;
            end
            if (!seen) begin
                read_csr(TVAL, now);
                checks++;
                assert (now <= prev) else begin
                    $display("ERR %0t ns: TVAL rose from %h to %h", $time, prev, now);
                    errors++;
                    test_errors++;
                end
                prev = now;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!seen) begin
            $display("%0t ns: timer bit did not appear within %0d cycles", $time, limit);
            errors++;
            test_errors++;
        end
    endtask

    // one operation per cycle and checked before the next edge
    task automatic run_op(input logic [63:0] op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] d, input logic [XLEN-1:0] e);
        if (op == "wr") begin
            wr_en = 1'b1;
            wr_addr = a[CSR_AW-1:0];
            wr_data = d;
        end else if (op == "rd") begin
            rd_addr = a[CSR_AW-1:0];
        end else if (op == "excp") begin
            excp_flush = 1'b1;
            ecode = ecode_e'(a[ECODE_W-1:0]);
            era_in = d;
            esubcode = e[ESUB_W-1:0];
        end else if (op == "ertn") begin
            ertn_flush = 1'b1;
        end else if (op == "irq") begin
            interrupt = d[HWI_W-1:0];
        end
        #88;
        if (op == "rd") begin
            check_value($sformatf("read %h", a[CSR_AW-1:0]), rd_data, e);
        end else if (op == "wr" && a[CSR_AW-1:0] == CRMD) begin
            check_value("plv on crmd write", XLEN'(plv), XLEN'(d[PLV_W-1:0]));
        end else if (op == "excp") begin
            check_value("plv on excp", XLEN'(plv), '0);
        end else if (op == "ertn") begin
            check_value("plv on ertn", XLEN'(plv), e);
        end else if (op == "int") begin
            check_value("has_int", XLEN'(has_int), e);
        end
        @(posedge clk);
        #1;
        if (op == "excp") begin
            check_value("era output", era, d);
        end else if (op == "wr" && a[CSR_AW-1:0] == EENTRY) begin
            check_value("eentry output", eentry, e);
        end
        wr_en = 1'b0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
    endtask

    initial begin
        int fd;
        int n;
        int lines;
        logic [63:0] op;
        logic [XLEN-1:0] f_addr;
        logic [XLEN-1:0] f_data;
        logic [XLEN-1:0] f_exp;
        logic [8*128-1:0] rest;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_addr = '0;
        excp_flush = 1'b0;
        ecode = INT;
        esubcode = '0;
        era_in = '0;
        ertn_flush = 1'b0;
        interrupt = '0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        checks = 0;
        fd = $fopen("dv/csr_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/csr_vectors.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            #1;
            reset = 1'b0;
            lines = 0;
            while (!$feof(fd) && lines < 200) begin
                lines++;
                n = $fscanf(fd, "%s", op);
                if (n == 1 && op == "#") begin
                    n = $fgets(rest, fd);
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
                    if (op == "end") begin
                        finish_test(f_addr);
                    end else if (op == "wtmr") begin
                        wait_timer_bit(int'(f_data));
                    end else begin
                        run_op(op, f_addr, f_data, f_exp);
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("vector file did not end within 200 lines");
                errors++;
            end
            $fclose(fd);
            // redirect target keeps only the 64-byte aligned base
            run_op("wr", XLEN'(EENTRY), 32'h1c008abc, 32'h1c008a80);
            run_op("rd", XLEN'(EENTRY), 32'h00000000, 32'h1c008a80);
            finish_test(7);
            $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== compile.f ====
src/csr_pkg.sv
src/csr_mode_regs.sv
src/csr_int_ctrl.sv
src/csr_timer.sv
src/csr_read_port.sv
src/csr_top.sv
dv/tb_csr_top.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module tb_csr_top \
		-Mdir $(OBJ_DIR) -o tb_csr_top

run: compile
	./$(OBJ_DIR)/tb_csr_top | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/csr_vectors.txt ====
# op addr data expect, all hex; end closes test number addr
# excp: addr=ecode data=era expect=esubcode; wtmr: data=cycle limit
rd 0000 00000000 00000008
wr 0030 a5a5a5a5 00000000
wr 0031 12345678 00000000
wr 0032 ffffffff 00000000
wr 0033 0f0f1234 00000000
rd 0030 00000000 a5a5a5a5
rd 0031 00000000 12345678
rd 0032 00000000 ffffffff
rd 0033 00000000 0f0f1234
rd 0044 00000000 00000000
end 0001 00000000 00000000
# exception entry with plv 3, ie 1
wr 0000 00000007 00000000
rd 0000 00000000 00000007
excp 000b 1c000040 00000005
rd 0000 00000000 00000000
rd 0001 00000000 00000007
rd 0005 00000000 014b0000
rd 0006 00000000 1c000040
ertn 0000 00000000 00000003
rd 0000 00000000 00000007
end 0002 00000000 00000000
wr 0000 00000002 00000000
excp 000c 00001000 00000000
rd 0000 00000000 00000000
end 0003 00000000 00000000
# hwi0 is status bit 2
wr 0000 00000004 00000000
wr 0004 00000004 00000000
irq 0000 00000001 00000000
int 0000 00000000 00000001
wr 0004 00000000 00000000
int 0000 00000000 00000000
wr 0004 00000004 00000000
int 0000 00000000 00000001
wr 0000 00000000 00000000
int 0000 00000000 00000000
irq 0000 00000000 00000000
end 0004 00000000 00000000
# one-shot, initval 3
wr 0041 0000000d 00000000
wtmr 0000 00000010 00000000
rd 0042 00000000 ffffffff
rd 0005 00000000 000c0800
wr 0044 00000001 00000000
rd 0005 00000000 000c0000
end 0005 00000000 00000000
# periodic, initval 2
wr 0041 0000000b 00000000
wtmr 0000 0000000c 00000000
wr 0044 00000001 00000000
wtmr 0000 0000000c 00000000
wr 0044 00000001 00000000
wr 0041 00000000 00000000
rd 0005 00000000 000c0000
end 0006 00000000 00000000
